/* design/line_buf_params.svh */
`ifndef LINE_BUF_PARAMS_SVH
`define LINE_BUF_PARAMS_SVH

// Storage address width, 2048 entries
`define LB_ADDR_W 11

// Destination flops per pointer synchronizer
`define LB_SYNC_STAGES 2

// Completed-line counter width
`define LB_LINE_CNT_W 16

`endif

/* design/line_buf_pkg.sv */
`include "line_buf_params.svh"

package line_buf_pkg;

    localparam int LB_DEPTH = 1 << `LB_ADDR_W; // Entries in the line storage

    // One RGB888 pixel, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Stored item, pixel plus end-of-line flag
    typedef struct packed {
        logic    last;
        rgb888_t pix;
    } lb_entry_t;

    typedef logic [`LB_ADDR_W-1:0] lb_addr_t; // Storage address

    // Address plus wrap bit, wrap bit separates full from empty
    typedef logic [`LB_ADDR_W:0] lb_ptr_t;

endpackage

/* design/line_ram_if.sv */
`timescale 1ns/1ps

interface line_ram_if
    import line_buf_pkg::*;
();

    // Write port, write clock domain
    logic      wr_clk;
    logic      wr_en;
    lb_addr_t  wr_addr;
    lb_entry_t wr_data;

    // Read port, R_AXIS_ACLK domain
    logic      rd_en;
    lb_addr_t  rd_addr;
    lb_entry_t rd_data; // Valid the cycle after the read edge

    modport writer (
        output wr_clk, wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_en, rd_addr,
        input  rd_data
    );

    modport ram (
        input  wr_clk, wr_en, wr_addr, wr_data,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

/* design/axis_line_writer.sv */
`timescale 1ns/1ps
`include "line_buf_params.svh"

module axis_line_writer
    import line_buf_pkg::*;
(
    input  logic     S_AXIS_ACLK,
    input  logic     S_AXIS_ARESETN,
    input  rgb888_t  s_axis_tdata,
    input  logic     s_axis_tvalid,
    input  logic     s_axis_tlast,
    input  lb_ptr_t  rd_ptr_sync,    // Read pointer seen in this domain
    output logic     s_axis_tready,
    output lb_ptr_t  wr_ptr,
    line_ram_if.writer ram
);

    logic    accept;
    lb_ptr_t wr_ptr_nxt;
    logic    full_nxt;

    assign accept = s_axis_tvalid & s_axis_tready; // AXI-Stream handshake

    assign wr_ptr_nxt = accept ? wr_ptr + lb_ptr_t'(1) : wr_ptr;

    // Same address, opposite wrap bit
    assign full_nxt = (wr_ptr_nxt[`LB_ADDR_W-1:0] == rd_ptr_sync[`LB_ADDR_W-1:0]) &&
                      (wr_ptr_nxt[`LB_ADDR_W] != rd_ptr_sync[`LB_ADDR_W]);

    // Accepted beat is written on the same edge
    assign ram.wr_clk       = S_AXIS_ACLK;
    assign ram.wr_en        = accept;
    assign ram.wr_addr      = wr_ptr[`LB_ADDR_W-1:0];
    assign ram.wr_data.pix  = s_axis_tdata;
    assign ram.wr_data.last = s_axis_tlast; // Line end kept with its pixel

    always_ff @(posedge S_AXIS_ACLK) begin
        if (!S_AXIS_ARESETN) begin
            wr_ptr        <= '0;
            s_axis_tready <= 1'b0; // Low through reset
        end else begin
            wr_ptr        <= wr_ptr_nxt;
            s_axis_tready <= ~full_nxt; // Drops on the beat that fills
        end
    end

endmodule

/* design/gray_ptr_sync.sv */
`timescale 1ns/1ps
`include "line_buf_params.svh"

module gray_ptr_sync
    import line_buf_pkg::*;
(
    input  logic    src_clk,
    input  logic    src_rst_n,
    input  logic    dst_clk,
    input  logic    dst_rst_n,
    input  lb_ptr_t src_ptr,
    output lb_ptr_t dst_ptr
);

    lb_ptr_t src_gray;                     // Launch register, source domain
    lb_ptr_t sync_q [`LB_SYNC_STAGES];     // Destination flop chain

    function automatic lb_ptr_t gray_to_bin(input lb_ptr_t gray);
        lb_ptr_t bin;
        bin[`LB_ADDR_W] = gray[`LB_ADDR_W];
        for (int i = `LB_ADDR_W - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // One bit changes per step, so any sample is old or new pointer
    always_ff @(posedge src_clk) begin
        if (!src_rst_n) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_ptr ^ (src_ptr >> 1);
        end
    end

    always_ff @(posedge dst_clk) begin
        if (!dst_rst_n) begin
            for (int i = 0; i < `LB_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= src_gray; // Crossing point
            for (int i = 1; i < `LB_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign dst_ptr = gray_to_bin(sync_q[`LB_SYNC_STAGES-1]);

endmodule

/* design/line_ram.sv */
`timescale 1ns/1ps

module line_ram
    import line_buf_pkg::*;
(
    input  logic    R_AXIS_ACLK,
    line_ram_if.ram ram
);

    lb_entry_t mem [LB_DEPTH]; // One line plus margin
    lb_entry_t rd_q;

    // Write side runs on the source clock
    always_ff @(posedge ram.wr_clk) begin
        if (ram.wr_en) begin
            mem[ram.wr_addr] <= ram.wr_data;
        end
    end

    // Registered read, holds when idle
    always_ff @(posedge R_AXIS_ACLK) begin
        if (ram.rd_en) begin
            rd_q <= mem[ram.rd_addr];
        end
    end

    assign ram.rd_data = rd_q;

endmodule

/* design/pixel_reader.sv */
`timescale 1ns/1ps
`include "line_buf_params.svh"

module pixel_reader
    import line_buf_pkg::*;
(
    input  logic                      R_AXIS_ACLK,
    input  logic                      R_AXIS_ARESETN,
    input  lb_ptr_t                   wr_ptr_sync,  // Write pointer seen in this domain
    output lb_ptr_t                   rd_ptr,
    output logic                      pix_valid,
    output rgb888_t                   pix_data,
    output logic                      pix_last,
    output logic [`LB_LINE_CNT_W-1:0] line_count,
    line_ram_if.reader                ram
);

    logic empty;
    logic rd_issue;
    logic rd_vld_q; // Read in flight, data lands this cycle

    assign empty    = (wr_ptr_sync == rd_ptr);
    assign rd_issue = ~empty; // No back-pressure on the output side

    assign ram.rd_en   = rd_issue;
    assign ram.rd_addr = rd_ptr[`LB_ADDR_W-1:0];

    // Strobe qualifies the entry returned by the storage
    assign pix_valid = rd_vld_q;
    assign pix_data  = ram.rd_data.pix;
    assign pix_last  = ram.rd_data.last;

    always_ff @(posedge R_AXIS_ACLK) begin
        if (!R_AXIS_ARESETN) begin
            rd_ptr     <= '0;
            rd_vld_q   <= 1'b0;
            line_count <= '0;
        end else begin
            rd_vld_q <= rd_issue;
            if (rd_issue) begin
                rd_ptr <= rd_ptr + lb_ptr_t'(1); // Back to back while data remains
            end
            if (rd_vld_q && ram.rd_data.last) begin
                line_count <= line_count + 1'b1; // One per completed line
            end
        end
    end

endmodule

/* design/line_buffer_top.sv */
`timescale 1ns/1ps
`include "line_buf_params.svh"

module line_buffer_top
    import line_buf_pkg::*;
(
    // Write clock domain
    input  logic                      S_AXIS_ACLK,
    input  logic                      S_AXIS_ARESETN,
    input  logic [23:0]               s_axis_tdata,
    input  logic                      s_axis_tvalid,
    input  logic                      s_axis_tlast,
    output logic                      s_axis_tready,

    // Read clock domain
    input  logic                      R_AXIS_ACLK,
    input  logic                      R_AXIS_ARESETN,
    output logic                      pix_valid,
    output logic [23:0]               pix_data,
    output logic                      pix_last,
    output logic [`LB_LINE_CNT_W-1:0] line_count
);

    lb_ptr_t wr_ptr;       // S_AXIS_ACLK domain
    lb_ptr_t wr_ptr_sync;  // Write pointer in R_AXIS_ACLK domain
    lb_ptr_t rd_ptr;       // R_AXIS_ACLK domain
    lb_ptr_t rd_ptr_sync;  // Read pointer in S_AXIS_ACLK domain

    line_ram_if u_ram_if ();

    axis_line_writer u_axis_line_writer (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tlast   (s_axis_tlast),
        .rd_ptr_sync    (rd_ptr_sync),
        .s_axis_tready  (s_axis_tready),
        .wr_ptr         (wr_ptr),
        .ram            (u_ram_if.writer)
    );

    line_ram u_line_ram (
        .R_AXIS_ACLK (R_AXIS_ACLK),
        .ram         (u_ram_if.ram)
    );

    // Write pointer into the read domain
    gray_ptr_sync u_wr2rd (
        .src_clk   (S_AXIS_ACLK),
        .src_rst_n (S_AXIS_ARESETN),
        .dst_clk   (R_AXIS_ACLK),
        .dst_rst_n (R_AXIS_ARESETN),
        .src_ptr   (wr_ptr),
        .dst_ptr   (wr_ptr_sync)
    );

    // Read pointer back into the write domain
    gray_ptr_sync u_rd2wr (
        .src_clk   (R_AXIS_ACLK),
        .src_rst_n (R_AXIS_ARESETN),
        .dst_clk   (S_AXIS_ACLK),
        .dst_rst_n (S_AXIS_ARESETN),
        .src_ptr   (rd_ptr),
        .dst_ptr   (rd_ptr_sync)
    );

    pixel_reader u_pixel_reader (
        .R_AXIS_ACLK    (R_AXIS_ACLK),
        .R_AXIS_ARESETN (R_AXIS_ARESETN),
        .wr_ptr_sync    (wr_ptr_sync),
        .rd_ptr         (rd_ptr),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .pix_last       (pix_last),
        .line_count     (line_count),
        .ram            (u_ram_if.reader)
    );

endmodule

/* tests/tb_line_buffer.sv */
`timescale 1ns/1ps
`include "line_buf_params.svh"

module tb_line_buffer;

    localparam int FULL_LINE   = 1280;
    localparam int BURST_LEN   = 6000;
    localparam int SHORT_LINES = 20;
    localparam int PRE_RST     = 200;
    localparam int AFTER_RST   = 32;
    localparam int PIX_TOTAL   = FULL_LINE + BURST_LEN + SHORT_LINES * 64 + PRE_RST + AFTER_RST;
    localparam int WDOG_CYCLES = 16 * PIX_TOTAL + 2000; // In R_AXIS_ACLK cycles

    logic                      R_AXIS_ACLK;
    logic                      R_AXIS_ARESETN;
    logic                      S_AXIS_ACLK;
    logic                      S_AXIS_ARESETN;
    logic [23:0]               s_axis_tdata;
    logic                      s_axis_tvalid;
    logic                      s_axis_tlast;
    logic                      s_axis_tready;
    logic                      pix_valid;
    logic [23:0]               pix_data;
    logic                      pix_last;
    logic [`LB_LINE_CNT_W-1:0] line_count;

    logic [24:0] exp_q [$];              // Accepted pixels with the last flag on top
    logic [24:0] exp_entry;
    logic [15:0] lfsr = 16'd28080;
    logic        saw_ready_low;
    int          fail_count;

    line_buffer_top u_line_buffer_top (
        .S_AXIS_ACLK    (S_AXIS_ACLK),
        .S_AXIS_ARESETN (S_AXIS_ARESETN),
        .s_axis_tdata   (s_axis_tdata),
        .s_axis_tvalid  (s_axis_tvalid),
        .s_axis_tlast   (s_axis_tlast),
        .s_axis_tready  (s_axis_tready),
        .R_AXIS_ACLK    (R_AXIS_ACLK),
        .R_AXIS_ARESETN (R_AXIS_ARESETN),
        .pix_valid      (pix_valid),
        .pix_data       (pix_data),
        .pix_last       (pix_last),
        .line_count     (line_count)
    );

    always #4   R_AXIS_ACLK = ~R_AXIS_ACLK; // 8 ns read clock
    always #2.5 S_AXIS_ACLK = ~S_AXIS_ACLK; // 5 ns write clock outpaces reads

    // Galois LFSR with taps 0xB400 stepped once per bit taken
    function automatic logic [23:0] take_bits(input int n);
        logic [23:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[22:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic report_failure(input string what);
        fail_count++;
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                                     $time, what, actual, expected));
        end
    endtask

    // Offers one beat and holds it until the writer takes it
    task automatic send_beat(input logic [23:0] data, input logic last);
        @(negedge S_AXIS_ACLK);
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = data;
        s_axis_tlast  = last;
        while (!s_axis_tready) begin
            saw_ready_low = 1'b1;
            @(negedge S_AXIS_ACLK);
        end
        exp_q.push_back({last, data}); // Taken on the next rising edge
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge S_AXIS_ACLK);
            s_axis_tvalid = 1'b0;
            s_axis_tlast  = 1'b0;
        end
    endtask

    task automatic drain();
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            @(negedge R_AXIS_ACLK);
        end
        repeat (2) @(negedge R_AXIS_ACLK); // line_count lags the last strobe
    endtask

    task automatic pulse_resets();
        @(negedge R_AXIS_ACLK);
        R_AXIS_ARESETN = 1'b0;
        S_AXIS_ARESETN = 1'b0;
        exp_q.delete(); // Stored pixels are dropped by the reset
        repeat (5) @(negedge R_AXIS_ACLK);
        R_AXIS_ARESETN = 1'b1;
        S_AXIS_ARESETN = 1'b1;
    endtask

    // Scoreboard pops one expected entry per output strobe
    always @(negedge R_AXIS_ACLK) begin
        if (R_AXIS_ARESETN && pix_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("output strobe arrived with no accepted pixel left to match");
            end else begin
                exp_entry = exp_q.pop_front();
                check_value(32'({pix_last, pix_data}), 32'(exp_entry), "pixel and last flag");
            end
        end
    end

    task automatic reset_state_test();
        int waited;
        repeat (5) begin
            @(negedge R_AXIS_ACLK);
            check_value(32'(s_axis_tready), 32'd0, "tready during reset");
            check_value(32'(pix_valid), 32'd0, "pix_valid during reset");
            check_value(32'(line_count), 32'd0, "line_count during reset");
        end
        R_AXIS_ARESETN = 1'b1;
        S_AXIS_ARESETN = 1'b1;
        waited = 0;
        while (!s_axis_tready && waited < 10) begin
            @(negedge S_AXIS_ACLK);
            waited++;
        end
        if (!s_axis_tready) begin
            report_failure("s_axis_tready stayed low for 10 write cycles after reset");
        end
    endtask

    task automatic full_line_test();
        for (int i = 0; i < FULL_LINE; i++) begin
            send_beat(take_bits(24), i == FULL_LINE - 1);
        end
        drain();
        check_value(32'(line_count), 32'd1, "line_count after one full line");
    endtask

    task automatic back_pressure_test();
        logic [`LB_LINE_CNT_W-1:0] start_cnt;
        start_cnt     = line_count;
        saw_ready_low = 1'b0;
        for (int i = 0; i < BURST_LEN; i++) begin
            send_beat(take_bits(24), i == BURST_LEN - 1);
        end
        drain();
        if (!saw_ready_low) begin
            report_failure("s_axis_tready never dropped while the storage was overrun");
        end
        check_value(32'(line_count), 32'(start_cnt + 1'b1), "line_count after burst");
    endtask

    task automatic short_lines_test();
        logic [`LB_LINE_CNT_W-1:0] start_cnt;
        int                        len;
        int                        gap;
        start_cnt = line_count;
        for (int l = 0; l < SHORT_LINES; l++) begin
            len = int'(take_bits(6)) + 1; // 1 to 64 pixels
            for (int i = 0; i < len; i++) begin
                send_beat(take_bits(24), i == len - 1);
                gap = int'(take_bits(3));
                if (gap > 0) begin
                    idle_cycles(gap);
                end
            end
        end
        drain();
        check_value(32'(line_count), 32'(start_cnt + 5'd20), "line_count after short lines");
    endtask

    task automatic mid_stream_reset_test();
        for (int i = 0; i < PRE_RST; i++) begin
            send_beat(take_bits(24), 1'b0);
        end
        idle_cycles(1);
        if (exp_q.size() == 0) begin
            report_failure("storage was already empty when the mid-stream reset began");
        end
        pulse_resets();
        repeat (20) begin
            @(negedge R_AXIS_ACLK);
            check_value(32'(pix_valid), 32'd0, "pix_valid after mid-stream reset");
            check_value(32'(line_count), 32'd0, "line_count after mid-stream reset");
        end
        for (int i = 0; i < AFTER_RST; i++) begin
            send_beat(take_bits(24), i == AFTER_RST - 1);
        end
        drain();
        check_value(32'(line_count), 32'd1, "line_count after fresh line");
    endtask

    initial begin
        repeat (WDOG_CYCLES) @(posedge R_AXIS_ACLK);
        report_failure("timeout: the tests did not finish within the cycle limit");
    end

    initial begin
        R_AXIS_ACLK    = 1'b0;
        S_AXIS_ACLK    = 1'b0;
        R_AXIS_ARESETN = 1'b0;
        S_AXIS_ARESETN = 1'b0;
        s_axis_tdata   = '0;
        s_axis_tvalid  = 1'b0;
        s_axis_tlast   = 1'b0;
        saw_ready_low  = 1'b0;
        fail_count     = 0;
        reset_state_test();
        full_line_test();
        back_pressure_test();
        short_lines_test();
        mid_stream_reset_test();
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/line_buf_pkg.sv
design/line_ram_if.sv
design/axis_line_writer.sv
design/gray_ptr_sync.sv
design/line_ram.sv
design/pixel_reader.sv
design/line_buffer_top.sv
tests/tb_line_buffer.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f vlog.f --top-module tb_line_buffer -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
